// File: files.f
lut_pkg.sv
lut_table.sv
lut_apb_regs.sv
lut_lookup_ctrl.sv
lut_top.sv
tb_lut_top.sv

// File: lut_apb_regs.sv
/*
 * lut apb slave: config and address registers, table data port
 * with one wait state on reads, bounds check and table strobes
 */
`timescale 1ns/1ps
`default_nettype none

module lut_apb_regs #(
  parameter int raw_depth     = lut_pkg::raw_depth_dflt,
  parameter int density_depth = lut_pkg::density_depth_dflt
) (
  input  wire                             nvdla_core_clk,
  input  wire                             nvdla_core_rstn,
  input  wire                             psel,
  input  wire                             penable,
  input  wire                             pwrite,
  input  wire [lut_pkg::apb_addr_w-1:0]   paddr,
  input  wire [lut_pkg::apb_data_w-1:0]   pwdata,
  input  wire [lut_pkg::entry_w-1:0]      raw_rd_data,
  input  wire [lut_pkg::entry_w-1:0]      density_rd_data,
  output logic [lut_pkg::apb_data_w-1:0]  prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            raw_wr_en,
  output logic                            raw_rd_en,
  output logic                            density_wr_en,
  output logic                            density_rd_en,
  output logic [lut_pkg::addr_w-1:0]      tbl_addr,
  output logic [lut_pkg::entry_w-1:0]     wr_data,
  output logic                            hybrid_prio,
  output logic                            oflow_prio,
  output logic                            uflow_prio
);

  localparam logic [lut_pkg::addr_w-1:0] raw_lim     = lut_pkg::addr_w'(raw_depth);
  localparam logic [lut_pkg::addr_w-1:0] density_lim = lut_pkg::addr_w'(density_depth);

  typedef enum logic {
    st_idle,
    st_rd_wait
  } apb_state_t;

  apb_state_t                 state;
  logic [lut_pkg::cfg_w-1:0]  cfg_q;
  logic [lut_pkg::addr_w-1:0] addr_q;
  logic                       table_id;
  logic                       access;
  logic                       sel_cfg;
  logic                       sel_addr;
  logic                       sel_data;
  logic                       unmapped;
  logic                       in_range;
  logic                       data_rd;
  logic                       complete;
  logic                       rd_go;
  logic                       wr_go;
  logic [lut_pkg::entry_w-1:0] tbl_rd_data;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign access   = psel & penable;
  assign sel_cfg  = (paddr == lut_pkg::reg_cfg);
  assign sel_addr = (paddr == lut_pkg::reg_addr);
  assign sel_data = (paddr == lut_pkg::reg_data);
  assign unmapped = ~(sel_cfg | sel_addr | sel_data);

  assign table_id    = cfg_q[lut_pkg::cfg_table_id_bit];
  assign hybrid_prio = cfg_q[lut_pkg::cfg_hybrid_bit];
  assign oflow_prio  = cfg_q[lut_pkg::cfg_oflow_bit];
  assign uflow_prio  = cfg_q[lut_pkg::cfg_uflow_bit];

  // bound depends on the selected table
  assign in_range = table_id ? (addr_q < density_lim) : (addr_q < raw_lim);

  // table reads are the only accesses that wait
  assign data_rd  = access & ~pwrite & sel_data;
  assign pready   = access & ((state == st_rd_wait) | ~data_rd);
  assign complete = access & pready;
  assign pslverr  = complete & (unmapped | (sel_data & ~in_range));

  //////////////////////////////////////////////////////////////////////
  // access fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:    if (data_rd) state <= st_rd_wait;
        st_rd_wait: state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  // table strobes, qualified by table_id
  assign rd_go = data_rd & (state == st_idle) & in_range;
  assign wr_go = complete & pwrite & sel_data & in_range;

  assign raw_rd_en     = rd_go & ~table_id;
  assign density_rd_en = rd_go & table_id;
  assign raw_wr_en     = wr_go & ~table_id;
  assign density_wr_en = wr_go & table_id;
  assign tbl_addr      = addr_q;
  assign wr_data       = pwdata[lut_pkg::entry_w-1:0];

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else if (complete & pwrite) begin
      if (sel_cfg) cfg_q <= pwdata[lut_pkg::cfg_w-1:0];
      if (sel_addr) addr_q <= pwdata[lut_pkg::addr_w-1:0];
    end
  end

  // read mux
  assign tbl_rd_data = table_id ? density_rd_data : raw_rd_data;

  always_comb begin
    prdata = '0;
    if (sel_cfg) begin
      prdata = lut_pkg::apb_data_w'(cfg_q);
    end else if (sel_addr) begin
      prdata = lut_pkg::apb_data_w'(addr_q);
    end else if (sel_data & in_range) begin
      prdata = lut_pkg::apb_data_w'(tbl_rd_data);
    end
  end

endmodule

`default_nettype wire

// File: lut_lookup_ctrl.sv
/*
 * lut lookup control: request handshake, x/y table selection,
 * info registers and 32-bit sign-extended output stage
 */
`timescale 1ns/1ps
`default_nettype none

module lut_lookup_ctrl (
  input  wire                              nvdla_core_clk,
  input  wire                              nvdla_core_rstn,
  input  wire                              req_valid,
  input  wire [lut_pkg::info_w-1:0]        x_info,
  input  wire [lut_pkg::info_w-1:0]        y_info,
  input  wire                              out_ready,
  input  wire                              hybrid_prio,
  input  wire                              oflow_prio,
  input  wire                              uflow_prio,
  input  wire [lut_pkg::entry_w-1:0]       x_data0,
  input  wire [lut_pkg::entry_w-1:0]       x_data1,
  input  wire [lut_pkg::entry_w-1:0]       y_data0,
  input  wire [lut_pkg::entry_w-1:0]       y_data1,
  output logic                             req_ready,
  output logic                             x_load,
  output logic                             y_load,
  output logic                             out_valid,
  output logic [lut_pkg::out_data_w-1:0]   out_data0,
  output logic [lut_pkg::out_data_w-1:0]   out_data1,
  output logic [lut_pkg::out_info_w-1:0]   out_info,
  output logic                             out_x_sel,
  output logic                             out_y_sel
);

  localparam int ext_w  = lut_pkg::out_data_w - lut_pkg::entry_w;
  localparam int frac_w = lut_pkg::uflow_bit;

  logic                        accept;
  logic [3:0]                  flags;
  logic                        x_sel;
  logic                        y_sel;
  logic [lut_pkg::info_w-1:0]  x_info_q;
  logic [lut_pkg::info_w-1:0]  y_info_q;
  logic [lut_pkg::entry_w-1:0] d0;
  logic [lut_pkg::entry_w-1:0] d1;
  logic [frac_w-1:0]           frac;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // stall only while a result waits downstream
  assign req_ready = ~out_valid | out_ready;
  assign accept    = req_valid & req_ready;

  //////////////////////////////////////////////////////////////////////
  // x/y selection
  //////////////////////////////////////////////////////////////////////

  assign flags = {x_info[lut_pkg::oflow_bit], x_info[lut_pkg::uflow_bit],
                  y_info[lut_pkg::oflow_bit], y_info[lut_pkg::uflow_bit]};

  always_comb begin
    x_sel = 1'b0;
    y_sel = 1'b0;
    case (flags)
      // both hit, or one under and the other over
      4'b0000, 4'b0110, 4'b1001: begin
        x_sel = ~hybrid_prio;
        y_sel = hybrid_prio;
      end
      // x hit only
      4'b0001, 4'b0010: x_sel = 1'b1;
      // y hit only
      4'b0100, 4'b1000: y_sel = 1'b1;
      // both under
      4'b0101: begin
        x_sel = ~uflow_prio;
        y_sel = uflow_prio;
      end
      // both over
      4'b1010: begin
        x_sel = ~oflow_prio;
        y_sel = oflow_prio;
      end
      // a side with both flags picks nothing
      default: begin
        x_sel = 1'b0;
        y_sel = 1'b0;
      end
    endcase
  end

  // table lookup registers load with the request
  assign x_load = accept & x_sel;
  assign y_load = accept & y_sel;

  //////////////////////////////////////////////////////////////////////
  // output stage registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
      out_x_sel <= 1'b0;
      out_y_sel <= 1'b0;
    end else begin
      if (accept) begin
        out_valid <= 1'b1;
        out_x_sel <= x_sel;
        out_y_sel <= y_sel;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (accept) begin
      x_info_q <= x_info;
      y_info_q <= y_info;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output formatting
  //////////////////////////////////////////////////////////////////////

  // zero when neither table chosen
  assign d0 = out_x_sel ? x_data0 : (out_y_sel ? y_data0 : '0);
  assign d1 = out_x_sel ? x_data1 : (out_y_sel ? y_data1 : '0);

  assign frac = out_x_sel ? x_info_q[frac_w-1:0] :
                (out_y_sel ? y_info_q[frac_w-1:0] : '0);

  assign out_data0 = {{ext_w{d0[lut_pkg::entry_w-1]}}, d0};
  assign out_data1 = {{ext_w{d1[lut_pkg::entry_w-1]}}, d1};

  // y flags, x flags, fraction
  assign out_info = {y_info_q[lut_pkg::oflow_bit], y_info_q[lut_pkg::uflow_bit],
                     x_info_q[lut_pkg::oflow_bit], x_info_q[lut_pkg::uflow_bit],
                     frac};

endmodule

`default_nettype wire

// File: lut_pkg.sv
/*
 * lut package: widths, table depths, info flag positions,
 * config bit positions and apb register offsets
 */
`default_nettype none

package lut_pkg;

  // table storage
  localparam int entry_w            = 16;
  localparam int addr_w             = 10;
  localparam int raw_depth_dflt     = 65;
  localparam int density_depth_dflt = 257;

  // request info word, {oflow, uflow, fraction[15:0]}
  localparam int info_w    = 18;
  localparam int oflow_bit = 17;
  localparam int uflow_bit = 16;

  // datapath output
  localparam int out_data_w = 32;
  localparam int out_info_w = 20;

  // apb bus
  localparam int apb_addr_w = 12;
  localparam int apb_data_w = 32;

  // register offsets
  localparam logic [apb_addr_w-1:0] reg_cfg  = 12'h000;
  localparam logic [apb_addr_w-1:0] reg_addr = 12'h004;
  localparam logic [apb_addr_w-1:0] reg_data = 12'h008;

  // config register fields
  localparam int cfg_w            = 4;
  localparam int cfg_table_id_bit = 0;
  localparam int cfg_hybrid_bit   = 1;
  localparam int cfg_oflow_bit    = 2;
  localparam int cfg_uflow_bit    = 3;

endpackage

`default_nettype wire

// File: lut_table.sv
/*
 * lut table: programmable entry array with a write port, registered
 * readback and a clamped two-entry lookup register
 */
`timescale 1ns/1ps
`default_nettype none

module lut_table #(
  parameter int depth = lut_pkg::raw_depth_dflt
) (
  input  wire                             nvdla_core_clk,
  input  wire                             nvdla_core_rstn,
  input  wire                             wr_en,
  input  wire                             rd_en,
  input  wire [lut_pkg::addr_w-1:0]       tbl_addr,
  input  wire [lut_pkg::entry_w-1:0]      wr_data,
  input  wire                             lkup_load,
  input  wire [lut_pkg::addr_w-1:0]       lkup_entry,
  input  wire [lut_pkg::info_w-1:0]       lkup_info,
  output logic [lut_pkg::entry_w-1:0]     rd_data,
  output logic [lut_pkg::entry_w-1:0]     lkup_data0,
  output logic [lut_pkg::entry_w-1:0]     lkup_data1
);

  // index width just wide enough for this depth
  localparam int idx_w = $clog2(depth);
  localparam logic [lut_pkg::addr_w-1:0] last_idx = lut_pkg::addr_w'(depth - 1);
  localparam logic [lut_pkg::addr_w-1:0] depth_c  = lut_pkg::addr_w'(depth);

  logic [lut_pkg::entry_w-1:0] mem [0:depth-1];
  logic [idx_w-1:0]            lkup_idx;
  logic [idx_w-1:0]            lkup_idx_nxt;
  logic [lut_pkg::entry_w-1:0] sel0;
  logic [lut_pkg::entry_w-1:0] sel1;

  //////////////////////////////////////////////////////////////////////
  // table write
  //////////////////////////////////////////////////////////////////////

  // entries come up as zero
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[tbl_addr[idx_w-1:0]] <= wr_data;
    end
  end

  // readback, valid from the cycle after rd_en
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      rd_data <= mem[tbl_addr[idx_w-1:0]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lookup pair
  //////////////////////////////////////////////////////////////////////

  assign lkup_idx     = lkup_entry[idx_w-1:0];
  assign lkup_idx_nxt = lkup_idx + idx_w'(1);

  always_comb begin
    if (lkup_info[lut_pkg::uflow_bit]) begin
      // underflow clamps to the first entry
      sel0 = mem[0];
      sel1 = mem[0];
    end else if (lkup_info[lut_pkg::oflow_bit]) begin
      // overflow clamps to the last entry
      sel0 = mem[depth-1];
      sel1 = mem[depth-1];
    end else if (lkup_entry == last_idx) begin
      // no successor past the end
      sel0 = mem[depth-1];
      sel1 = mem[depth-1];
    end else if (lkup_entry >= depth_c) begin
      // out of range index
      sel0 = mem[0];
      sel1 = mem[0];
    end else begin
      sel0 = mem[lkup_idx];
      sel1 = mem[lkup_idx_nxt];
    end
  end

  // loads on accepted request only, holds otherwise
  always_ff @(posedge nvdla_core_clk) begin
    if (lkup_load) begin
      lkup_data0 <= sel0;
      lkup_data1 <= sel1;
    end
  end

endmodule

`default_nettype wire

// File: lut_top.sv
/*
 * lut top: apb register block, raw and density tables, lookup control
 */
`timescale 1ns/1ps
`default_nettype none

module lut_top #(
  parameter int raw_depth     = lut_pkg::raw_depth_dflt,
  parameter int density_depth = lut_pkg::density_depth_dflt
) (
  input  wire                              nvdla_core_clk,
  input  wire                              nvdla_core_rstn,
  // apb
  input  wire                              psel,
  input  wire                              penable,
  input  wire                              pwrite,
  input  wire [lut_pkg::apb_addr_w-1:0]    paddr,
  input  wire [lut_pkg::apb_data_w-1:0]    pwdata,
  output wire [lut_pkg::apb_data_w-1:0]    prdata,
  output wire                              pready,
  output wire                              pslverr,
  // lookup request
  input  wire                              req_valid,
  input  wire [lut_pkg::addr_w-1:0]        x_entry,
  input  wire [lut_pkg::info_w-1:0]        x_info,
  input  wire [lut_pkg::addr_w-1:0]        y_entry,
  input  wire [lut_pkg::info_w-1:0]        y_info,
  output wire                              req_ready,
  // lookup result
  output wire                              out_valid,
  output wire [lut_pkg::out_data_w-1:0]    out_data0,
  output wire [lut_pkg::out_data_w-1:0]    out_data1,
  output wire [lut_pkg::out_info_w-1:0]    out_info,
  output wire                              out_x_sel,
  output wire                              out_y_sel,
  input  wire                              out_ready
);

  wire                        raw_wr_en;
  wire                        raw_rd_en;
  wire                        density_wr_en;
  wire                        density_rd_en;
  wire [lut_pkg::addr_w-1:0]  tbl_addr;
  wire [lut_pkg::entry_w-1:0] wr_data;
  wire [lut_pkg::entry_w-1:0] raw_rd_data;
  wire [lut_pkg::entry_w-1:0] density_rd_data;
  wire                        hybrid_prio;
  wire                        oflow_prio;
  wire                        uflow_prio;
  wire                        x_load;
  wire                        y_load;
  wire [lut_pkg::entry_w-1:0] x_data0;
  wire [lut_pkg::entry_w-1:0] x_data1;
  wire [lut_pkg::entry_w-1:0] y_data0;
  wire [lut_pkg::entry_w-1:0] y_data1;

  lut_apb_regs #(
    .raw_depth     (raw_depth),
    .density_depth (density_depth)
  ) u_apb_regs (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .raw_rd_data     (raw_rd_data),
    .density_rd_data (density_rd_data),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .raw_wr_en       (raw_wr_en),
    .raw_rd_en       (raw_rd_en),
    .density_wr_en   (density_wr_en),
    .density_rd_en   (density_rd_en),
    .tbl_addr        (tbl_addr),
    .wr_data         (wr_data),
    .hybrid_prio     (hybrid_prio),
    .oflow_prio      (oflow_prio),
    .uflow_prio      (uflow_prio)
  );

  // x side reads the raw table
  lut_table #(.depth(raw_depth)) u_raw_table (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_en           (raw_wr_en),
    .rd_en           (raw_rd_en),
    .tbl_addr        (tbl_addr),
    .wr_data         (wr_data),
    .lkup_load       (x_load),
    .lkup_entry      (x_entry),
    .lkup_info       (x_info),
    .rd_data         (raw_rd_data),
    .lkup_data0      (x_data0),
    .lkup_data1      (x_data1)
  );

  // y side reads the density table
  lut_table #(.depth(density_depth)) u_density_table (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_en           (density_wr_en),
    .rd_en           (density_rd_en),
    .tbl_addr        (tbl_addr),
    .wr_data         (wr_data),
    .lkup_load       (y_load),
    .lkup_entry      (y_entry),
    .lkup_info       (y_info),
    .rd_data         (density_rd_data),
    .lkup_data0      (y_data0),
    .lkup_data1      (y_data1)
  );

  lut_lookup_ctrl u_lookup_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_valid       (req_valid),
    .x_info          (x_info),
    .y_info          (y_info),
    .out_ready       (out_ready),
    .hybrid_prio     (hybrid_prio),
    .oflow_prio      (oflow_prio),
    .uflow_prio      (uflow_prio),
    .x_data0         (x_data0),
    .x_data1         (x_data1),
    .y_data0         (y_data0),
    .y_data1         (y_data1),
    .req_ready       (req_ready),
    .x_load          (x_load),
    .y_load          (y_load),
    .out_valid       (out_valid),
    .out_data0       (out_data0),
    .out_data1       (out_data1),
    .out_info        (out_info),
    .out_x_sel       (out_x_sel),
    .out_y_sel       (out_y_sel)
  );

endmodule

`default_nettype wire

// File: lut_vectors.txt
# lut_top vectors, all fields hex
# W paddr pwdata pslverr | R paddr prdata pslverr
# L x_entry x_info y_entry y_info data0 data1 info x_sel y_sel
W 000 0 0
W 004 0 0
W 008 1111 0
W 004 5 0
W 008 0505 0
W 004 6 0
W 008 8606 0
R 008 8606 0
W 004 40 0
W 008 7040 0
R 008 7040 0
W 004 80 0
W 008 dead 1
R 008 0 1
W 004 0 0
R 008 1111 0
W 000 1 0
R 000 1 0
W 008 2222 0
W 004 80 0
W 008 0080 0
R 008 0080 0
W 004 81 0
W 008 ff81 0
W 004 100 0
W 008 3100 0
W 004 200 0
R 004 200 0
W 008 beef 1
W 004 0 0
R 008 2222 0
W 00c 5 1
R 010 0 1
W 000 0 0
L 005 00abc 080 01234 00000505 ffff8606 00abc 1 0
L 040 00111 000 10777 00007040 00007040 40111 1 0
L 000 20222 080 00333 00000080 ffffff81 20333 0 1
L 000 10005 000 10006 00001111 00001111 50005 1 0
L 000 20007 000 20008 00007040 00007040 a0007 1 0
L 000 30009 000 0000a 00000000 00000000 30000 0 0
L 000 1000b 000 2000c 00001111 00001111 9000b 1 0
L 000 00009 000 20000 00001111 00000000 80009 1 0
L 050 0000d 000 10000 00001111 00001111 4000d 1 0
W 000 e 0
R 000 e 0
L 005 000aa 100 000bb 00003100 00003100 000bb 0 1
L 000 10001 000 10002 00002222 00002222 50002 0 1
L 000 20003 000 20004 00003100 00003100 a0004 0 1
L 000 00006 000 30005 00000000 00000000 c0000 0 0
L 000 10007 000 20008 00003100 00003100 90008 0 1

// File: run_sim.sh
#!/bin/sh
# build and run the lut_top testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lut_top -f files.f -o sim_lut
out=$(./obj_dir/sim_lut)
echo "$out"

if echo "$out" | grep -q -F '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

// File: tb_lut_top.sv
/*
 * lut_top testbench: vector driven apb programming, readback and
 * lookups checked against expected values under random back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lut_top;

  // packed result: data0, data1, info, x_sel, y_sel
  localparam int res_w = 2 * lut_pkg::out_data_w + lut_pkg::out_info_w + 2;

  logic                              nvdla_core_clk;
  logic                              nvdla_core_rstn;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [lut_pkg::apb_addr_w-1:0]    paddr;
  logic [lut_pkg::apb_data_w-1:0]    pwdata;
  wire  [lut_pkg::apb_data_w-1:0]    prdata;
  wire                               pready;
  wire                               pslverr;
  logic                              req_valid;
  logic [lut_pkg::addr_w-1:0]        x_entry;
  logic [lut_pkg::info_w-1:0]        x_info;
  logic [lut_pkg::addr_w-1:0]        y_entry;
  logic [lut_pkg::info_w-1:0]        y_info;
  wire                               req_ready;
  wire                               out_valid;
  wire  [lut_pkg::out_data_w-1:0]    out_data0;
  wire  [lut_pkg::out_data_w-1:0]    out_data1;
  wire  [lut_pkg::out_info_w-1:0]    out_info;
  wire                               out_x_sel;
  wire                               out_y_sel;
  logic                              out_ready;

  wire  [res_w-1:0] result = {out_data0, out_data1, out_info, out_x_sel, out_y_sel};

  integer           seed;
  integer           rnd;
  integer           errors;
  integer           checks;
  integer           cycles;
  integer           cycle_limit;
  logic [res_w-1:0] exp_q[$];
  logic [res_w-1:0] held;
  logic             stalled;
  logic [31:0]      fld [0:8];
  string            lines[$];

  lut_top u_dut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .req_valid       (req_valid),
    .x_entry         (x_entry),
    .x_info          (x_info),
    .y_entry         (y_entry),
    .y_info          (y_info),
    .req_ready       (req_ready),
    .out_valid       (out_valid),
    .out_data0       (out_data0),
    .out_data1       (out_data1),
    .out_info        (out_info),
    .out_x_sel       (out_x_sel),
    .out_y_sel       (out_y_sel),
    .out_ready       (out_ready)
  );

  always #50 nvdla_core_clk = ~nvdla_core_clk;

  // random back-pressure, changes just after each rising edge
  always @(posedge nvdla_core_clk) begin
    #1;
    rnd = $random(seed);
    out_ready = rnd[0];
  end

  // run limit
  always @(posedge nvdla_core_clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output monitor, samples at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      // a stalled result must not move
      if (stalled) begin
        if (!out_valid || result != held) begin
          $display("** Error at %0t: output changed while stalled", $time);
          errors = errors + 1;
        end
      end
      if (out_valid && !out_ready && req_ready) begin
        $display("** Error at %0t: req_ready high while output stalled", $time);
        errors = errors + 1;
      end
      stalled = out_valid & ~out_ready;
      held    = result;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("result delivered with no request outstanding at %0t", $time);
          errors = errors + 1;
        end else begin
          checks = checks + 1;
          if (result != exp_q[0]) begin
            $display("** Error at %0t: lookup got d0 %h d1 %h info %h sel %b%b, expected %h",
                     $time, out_data0, out_data1, out_info, out_x_sel, out_y_sel,
                     exp_q[0]);
            errors = errors + 1;
          end
          exp_q.pop_front();
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // apb and lookup drivers
  //////////////////////////////////////////////////////////////////////

  // one transfer, counts access cycles spent waiting
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
    int n;
    n       = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge nvdla_core_clk);
    #1;
    penable = 1'b1;
    @(negedge nvdla_core_clk);
    while (!pready) begin
      n = n + 1;
      @(negedge nvdla_core_clk);
    end
    rdata = prdata;
    err   = pslverr;
    waits = n;
    @(posedge nvdla_core_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_apb(input logic wr, input logic [31:0] addr, input logic [31:0] val,
                           input logic [31:0] exp_err);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    int          exp_waits;
    apb_access(wr, addr[11:0], wr ? val : 32'h0, rdata, err, waits);
    // only reg_data reads take a wait state
    exp_waits = (!wr && addr[11:0] == 12'h008) ? 1 : 0;
    checks    = checks + 1;
    if (waits != exp_waits) begin
      $display("** Error at %0t: addr %h took %0d wait states, expected %0d",
               $time, addr[11:0], waits, exp_waits);
      errors = errors + 1;
    end
    if (err != exp_err[0]) begin
      $display("** Error at %0t: addr %h pslverr %b, expected %b", $time, addr[11:0], err,
               exp_err[0]);
      errors = errors + 1;
    end
    if (!wr && rdata != val) begin
      $display("** Error at %0t: addr %h read %h, expected %h", $time, addr[11:0], rdata, val);
      errors = errors + 1;
    end
  endtask

  // holds the request until it is taken
  task automatic issue_lookup(input logic [9:0] xe, input logic [17:0] xi,
                              input logic [9:0] ye, input logic [17:0] yi,
                              input logic [res_w-1:0] expd);
    logic taken;
    taken     = 1'b0;
    req_valid = 1'b1;
    x_entry   = xe;
    x_info    = xi;
    y_entry   = ye;
    y_info    = yi;
    while (!taken) begin
      @(negedge nvdla_core_clk);
      if (req_ready) begin
        exp_q.push_back(expd);
        taken = 1'b1;
      end
      @(posedge nvdla_core_clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int         fd;
    int         n;
    string      line;
    string      rest;
    logic [7:0] op;
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req_valid = 1'b0;
    x_entry   = '0;
    x_info    = '0;
    y_entry   = '0;
    y_info    = '0;
    out_ready = 1'b0;
    seed      = 93974;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    stalled   = 1'b0;
    held      = '0;
    fd = $fopen("lut_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open lut_vectors.txt, no vectors were run");
      errors = errors + 1;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    // 40 cycles per vector line, plus reset
    cycle_limit = 40 * lines.size() + 10;
    repeat (2) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    foreach (lines[i]) begin
      op   = lines[i].getc(0);
      rest = lines[i].substr(1, lines[i].len() - 1);
      if (op == "W" || op == "R") begin
        n = $sscanf(rest, "%h %h %h", fld[0], fld[1], fld[2]);
        if (n != 3) begin
          $display("malformed apb vector line: %s", lines[i]);
          errors = errors + 1;
        end else begin
          check_apb(op == "W", fld[0], fld[1], fld[2]);
        end
      end else if (op == "L") begin
        n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3],
                    fld[4], fld[5], fld[6], fld[7], fld[8]);
        if (n != 9) begin
          $display("malformed lookup vector line: %s", lines[i]);
          errors = errors + 1;
        end else begin
          issue_lookup(fld[0][9:0], fld[1][17:0], fld[2][9:0], fld[3][17:0],
                       {fld[4], fld[5], fld[6][19:0], fld[7][0], fld[8][0]});
        end
      end else begin
        $display("unknown vector operation in line: %s", lines[i]);
        errors = errors + 1;
      end
    end
    // drain outstanding results
    while (exp_q.size() != 0) begin
      @(negedge nvdla_core_clk);
    end
    repeat (3) @(negedge nvdla_core_clk);
    if (out_valid) begin
      $display("output still valid after all results were taken");
      errors = errors + 1;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
